//--- list.f
logic/serial_bus_pkg.sv
logic/axil_pkg.sv
logic/bit_shifter.sv
logic/axil_front.sv
logic/bus_master.sv
logic/mem_slave.sv
logic/serial_bus_top.sv
verif/serial_bus_tb.sv

//--- Bender.yml
package:
  name: serial_bus

sources:
  - files:
      - logic/serial_bus_pkg.sv
      - logic/axil_pkg.sv
      - logic/bit_shifter.sv
      - logic/axil_front.sv
      - logic/bus_master.sv
      - logic/mem_slave.sv
      - logic/serial_bus_top.sv
  - target: simulation
    files:
      - verif/serial_bus_tb.sv

//--- verif/serial_bus_tb.sv
`timescale 1ns/1ps

module serial_bus_tb import serial_bus_pkg::*, axil_pkg::*;;

    localparam int TB_DEPTH       = 1024;
    localparam int RANDOM_TXN     = 200;
    // basic 6, decode error 5, strobe error 2, plus the random run
    localparam int NUM_TXN        = 6 + 5 + 2 + RANDOM_TXN;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 80 + 100;

    typedef struct packed {
        logic       is_write;
        logic       data_known;
        axil_resp_t resp;
        data_t      data;
    } expect_t;

    logic     clk;
    logic     rstN;
    axil_aw_t aw;
    logic     awvalid;
    logic     awready;
    axil_w_t  w;
    logic     wvalid;
    logic     wready;
    axil_b_t  b;
    logic     bvalid;
    logic     bready;
    axil_ar_t ar;
    logic     arvalid;
    logic     arready;
    axil_r_t  r;
    logic     rvalid;
    logic     rready;

    data_t       model_mem   [SLAVE_COUNT][TB_DEPTH];
    bit          model_known [SLAVE_COUNT][TB_DEPTH];
    expect_t     exp_q[$];
    logic [31:0] rng_state = 32'd92;
    int          cycle_count = 0;

    serial_bus_top #(
        .ADDR_DEPTH(TB_DEPTH)
    ) u_serial_bus_top (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected B or R result, model memory follows every accepted write
    function automatic expect_t expected_response(input logic is_write,
            input logic [15:0] host_addr, input data_t data, input logic [3:0] strb);
        expect_t    e;
        logic [1:0] sid;
        int         idx;
        sid          = host_addr[15:14];
        idx          = int'(host_addr[13:2]) % TB_DEPTH;
        e.is_write   = is_write;
        e.data       = '0;
        e.data_known = 1'b1;
        if (sid == 2'd0 || (is_write && strb != 4'hf)) begin
            e.resp = RESP_SLVERR;
        end else begin
            e.resp = RESP_OKAY;
            if (is_write) begin
                model_mem[sid-1][idx]   = data;
                model_known[sid-1][idx] = 1'b1;
            end else begin
                e.data       = model_mem[sid-1][idx];
                e.data_known = model_known[sid-1][idx];
            end
        end
        return e;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_quiet_outputs();
        check_value("awready", 0, awready);
        check_value("wready", 0, wready);
        check_value("arready", 0, arready);
        check_value("bvalid", 0, bvalid);
        check_value("rvalid", 0, rvalid);
    endtask

    // stall the response, probing that no new request gets in meanwhile
    task automatic hold_response(input logic is_write, input int hold);
        axil_b_t b_seen;
        axil_r_t r_seen;
        do @(posedge clk); while (!(is_write ? bvalid : rvalid));
        b_seen = b;
        r_seen = r;
        repeat (hold) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            arvalid <= 1'b1;
            @(posedge clk);
            check_value("awready", 0, awready);
            check_value("arready", 0, arready);
            if (is_write) begin
                check_value("bvalid", 1, bvalid);
                check_value("b", b_seen, b);
            end else begin
                check_value("rvalid", 1, rvalid);
                check_value("r", r_seen, r);
            end
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b0;
        if (is_write) bready <= 1'b1;
        else rready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic host_write(input logic [15:0] host_addr, input data_t data,
                              input logic [3:0] strb);
        int hold;
        hold = int'(xorshift32() % 8);
        exp_q.push_back(expected_response(1'b1, host_addr, data, strb));
        aw.addr <= host_addr;
        aw.prot <= 3'b000;
        w.data  <= data;
        w.strb  <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!awready);
        // address and data are taken in the same cycle
        check_value("wready", 1, wready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        hold_response(1'b1, hold);
    endtask

    task automatic host_read(input logic [15:0] host_addr);
        int hold;
        hold = int'(xorshift32() % 8);
        exp_q.push_back(expected_response(1'b0, host_addr, '0, 4'hf));
        ar.addr <= host_addr;
        ar.prot <= 3'b000;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        hold_response(1'b0, hold);
    endtask

    always @(posedge clk) begin : compare_responses
        expect_t e;
        if (rstN && ((bvalid && bready) || (rvalid && rready))) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("a response arrived with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                // only the channel of the open transaction may answer
                if (e.is_write) begin
                    check_value("rvalid", 0, rvalid);
                    check_value("b.resp", e.resp, b.resp);
                end else begin
                    check_value("bvalid", 0, bvalid);
                    check_value("r.resp", e.resp, r.resp);
                    // unwritten words hold no defined value
                    if (e.data_known) check_value("r.data", e.data, r.data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles, DUT stopped responding",
                                        cycle_count));
        end
    end

    initial begin
        logic [1:0]  sid;
        logic [11:0] word;
        logic [31:0] pick;
        int          i;
        clk     = 1'b0;
        rstN    = 1'b0;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        ar      = '0;
        arvalid = 1'b0;
        rready  = 1'b0;

        repeat (4) begin
            @(posedge clk);
            check_quiet_outputs();
        end
        rstN <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_quiet_outputs();
        end

        // write then read back word 5 on every slave
        for (i = 1; i <= SLAVE_COUNT; i++) begin
            host_write({2'(i), 12'd5, 2'b00}, 32'h5a5a_0000 + i, 4'hf);
            host_read({2'(i), 12'd5, 2'b00});
        end

        // identity 0 must not reach any slave
        host_write({2'd0, 12'd5, 2'b00}, 32'hdead_beef, 4'hf);
        host_read({2'd0, 12'd5, 2'b00});
        for (i = 1; i <= SLAVE_COUNT; i++) begin
            host_read({2'(i), 12'd5, 2'b00});
        end

        // partial strobe leaves the old word
        host_write({2'd2, 12'd5, 2'b00}, 32'hffff_ffff, 4'b0011);
        host_read({2'd2, 12'd5, 2'b00});

        // small pool of words and its aliases above the depth
        for (i = 0; i < RANDOM_TXN; i++) begin
            pick = xorshift32();
            sid  = 2'(pick % 3 + 1);
            word = 12'((xorshift32() % 8) + 1024 * (xorshift32() % 4));
            if (pick[8]) host_write({sid, word, 2'(xorshift32())}, xorshift32(), 4'hf);
            else host_read({sid, word, 2'(xorshift32())});
        end

        @(posedge clk);
        if (exp_q.size() != 0) begin
            stop_with_failure($sformatf("%0d responses never arrived", exp_q.size()));
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- logic/serial_bus_top.sv
`timescale 1ns/1ps

module serial_bus_top import serial_bus_pkg::*, axil_pkg::*; #(
    parameter int ADDR_DEPTH = 1024
) (
    input  logic     clk,
    input  logic     rstN,
    input  axil_aw_t aw,
    input  logic     awvalid,
    output logic     awready,
    input  axil_w_t  w,
    input  logic     wvalid,
    output logic     wready,
    output axil_b_t  b,
    output logic     bvalid,
    input  logic     bready,
    input  axil_ar_t ar,
    input  logic     arvalid,
    output logic     arready,
    output axil_r_t  r,
    output logic     rvalid,
    input  logic     rready
);

    bus_req_t               req;
    logic                   req_valid;
    logic                   req_ready;
    bus_rsp_t               rsp;
    logic                   rsp_done;
    logic                   control;
    logic                   wD;
    logic                   valid;
    logic [SLAVE_COUNT-1:0] rD;
    logic [SLAVE_COUNT-1:0] ready;

    axil_front u_axil_front (.*);

    bus_master u_bus_master (.*);

    // lane i belongs to identity i+1
    for (genvar i = 0; i < SLAVE_COUNT; i++) begin : g_slave
        mem_slave #(
            .ADDR_DEPTH(ADDR_DEPTH),
            .SLAVE_ID  (SID_WIDTH'(i + 1))
        ) u_mem_slave (
            .clk    (clk),
            .rstN   (rstN),
            .control(control),
            .wD     (wD),
            .valid  (valid),
            .rD     (rD[i]),
            .ready  (ready[i])
        );
    end

endmodule

//--- logic/mem_slave.sv
`timescale 1ns/1ps

module mem_slave import serial_bus_pkg::*; #(
    parameter int                   ADDR_DEPTH = 1024,
    parameter logic [SID_WIDTH-1:0] SLAVE_ID   = 2'd1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    output logic rD,
    output logic ready
);

    localparam int AW    = $clog2(ADDR_DEPTH);
    localparam int CNT_W = $clog2(DATA_WIDTH);

    typedef enum logic [2:0] {
        IDLE,
        CAPTURE,
        DECODE,
        WDATA,
        STORE,
        ACK,
        RDATA
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] bit_cnt;
    data_t            ram [ADDR_DEPTH];
    ctrl_frame_t      frame;
    logic [AW-1:0]    addr;
    logic             match;
    logic             frame_shift;
    logic             take_wd;
    logic             data_load;
    logic             data_shift;
    logic             data_out;
    data_t            data_word;

    // upper word address bits are dropped, so addresses wrap
    assign addr  = frame.word_addr[AW-1:0];
    assign match = (frame.start == START_CODE) && (frame.slave_id == SLAVE_ID);

    assign frame_shift = ((state == IDLE) && control) || (state == CAPTURE);

    // first write bit already shows up while the frame is decoded
    assign take_wd    = valid && (((state == DECODE) && match && frame.write)
                                  || (state == WDATA));
    assign data_load  = (state == DECODE) && match && !frame.write;
    assign data_shift = take_wd || (state == RDATA);

    assign rD    = (state == RDATA) && data_out;
    assign ready = (state == RDATA) || (state == ACK);

    bit_shifter #(
        .payload_t(ctrl_frame_t)
    ) u_frame_shifter (
        .clk       (clk),
        .rstN      (rstN),
        .load      (1'b0),
        .load_value('0),
        .shift_en  (frame_shift),
        .serial_in (control),
        .serial_out(),
        .value     (frame)
    );

    bit_shifter #(
        .payload_t(data_t)
    ) u_data_shifter (
        .clk       (clk),
        .rstN      (rstN),
        .load      (data_load),
        .load_value(ram[addr]),
        .shift_en  (data_shift),
        .serial_in (wD),
        .serial_out(data_out),
        .value     (data_word)
    );

    always_ff @(posedge clk) begin
        if (state == STORE) begin
            ram[addr] <= data_word;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                // a frame always opens with a 1 on control
                IDLE: begin
                    if (control) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                        bit_cnt <= '0;
                        state   <= DECODE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                DECODE: begin
                    if (!match) begin
                        state <= IDLE;
                    end else if (frame.write) begin
                        bit_cnt <= CNT_W'(take_wd);
                        state   <= WDATA;
                    end else begin
                        state <= RDATA;
                    end
                end
                WDATA: begin
                    if (valid) begin
                        if (bit_cnt == CNT_W'(DATA_WIDTH - 1)) begin
                            bit_cnt <= '0;
                            state   <= STORE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                STORE: state <= ACK;
                ACK: state <= IDLE;
                RDATA: begin
                    if (bit_cnt == CNT_W'(DATA_WIDTH - 1)) begin
                        bit_cnt <= '0;
                        state   <= IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- logic/bus_master.sv
`timescale 1ns/1ps

module bus_master import serial_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  bus_req_t               req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output bus_rsp_t               rsp,
    output logic                   rsp_done,
    output logic                   control,
    output logic                   wD,
    output logic                   valid,
    input  logic [SLAVE_COUNT-1:0] rD,
    input  logic [SLAVE_COUNT-1:0] ready
);

    localparam int CNT_W = $clog2(DATA_WIDTH);

    typedef enum logic [2:0] {
        IDLE,
        FRAME,
        WDATA,
        WACK,
        RDATA
    } state_t;

    state_t               state;
    logic [CNT_W-1:0]     bit_cnt;
    logic [SID_WIDTH-1:0] lane;
    logic                 is_write;
    logic                 accept;
    ctrl_frame_t          frame;
    logic                 data_shift;
    logic                 data_out;
    data_t                data_word;
    logic                 lane_rd;
    logic                 lane_ready;

    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;
    assign valid     = (state == WDATA);

    assign frame = '{
        start:     START_CODE,
        slave_id:  req.slave_id,
        write:     req.write,
        word_addr: req.word_addr
    };

    // only the addressed slave's lane is heard
    assign lane_rd    = rD[lane];
    assign lane_ready = ready[lane];

    assign data_shift = valid || ((state == RDATA) && lane_ready);
    assign wD         = valid && data_out;
    assign rsp.rdata  = data_word;

    // zero fill keeps control low after the last frame bit
    bit_shifter #(
        .payload_t(ctrl_frame_t)
    ) u_frame_shifter (
        .clk       (clk),
        .rstN      (rstN),
        .load      (accept),
        .load_value(frame),
        .shift_en  (state == FRAME),
        .serial_in (1'b0),
        .serial_out(control),
        .value     ()
    );

    // write word goes out msb first, read word comes back in
    bit_shifter #(
        .payload_t(data_t)
    ) u_data_shifter (
        .clk       (clk),
        .rstN      (rstN),
        .load      (accept),
        .load_value(req.wdata),
        .shift_en  (data_shift),
        .serial_in (lane_rd),
        .serial_out(data_out),
        .value     (data_word)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            lane     <= '0;
            is_write <= 1'b0;
            rsp_done <= 1'b0;
        end else begin
            rsp_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        lane     <= req.slave_id - 1'b1;
                        is_write <= req.write;
                        bit_cnt  <= '0;
                        state    <= FRAME;
                    end
                end
                FRAME: begin
                    if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                        bit_cnt <= '0;
                        state   <= is_write ? WDATA : RDATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                WDATA: begin
                    if (bit_cnt == CNT_W'(DATA_WIDTH - 1)) begin
                        bit_cnt <= '0;
                        state   <= WACK;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                // one-cycle ready pulse from the slave
                WACK: begin
                    if (lane_ready) begin
                        rsp_done <= 1'b1;
                        state    <= IDLE;
                    end
                end
                RDATA: begin
                    if (lane_ready) begin
                        if (bit_cnt == CNT_W'(DATA_WIDTH - 1)) begin
                            bit_cnt  <= '0;
                            rsp_done <= 1'b1;
                            state    <= IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- logic/axil_front.sv
`timescale 1ns/1ps

module axil_front import serial_bus_pkg::*, axil_pkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  axil_aw_t aw,
    input  logic     awvalid,
    output logic     awready,
    input  axil_w_t  w,
    input  logic     wvalid,
    output logic     wready,
    output axil_b_t  b,
    output logic     bvalid,
    input  logic     bready,
    input  axil_ar_t ar,
    input  logic     arvalid,
    output logic     arready,
    output axil_r_t  r,
    output logic     rvalid,
    input  logic     rready,
    output bus_req_t req,
    output logic     req_valid,
    input  logic     req_ready,
    input  bus_rsp_t rsp,
    input  logic     rsp_done
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        BUSY,
        B_RESP,
        R_RESP
    } state_t;

    state_t               state;
    logic                 wr_accept;
    logic                 rd_accept;
    logic [SID_WIDTH-1:0] wr_sid;
    logic [SID_WIDTH-1:0] rd_sid;
    logic                 wr_error;
    logic                 rd_error;

    // write wins when both directions are pending
    assign wr_accept = (state == IDLE) && awvalid && wvalid;
    assign rd_accept = (state == IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;

    // top address bits pick the slave
    assign wr_sid = aw.addr[AXIL_ADDR_W-1 -: SID_WIDTH];
    assign rd_sid = ar.addr[AXIL_ADDR_W-1 -: SID_WIDTH];

    assign wr_error = (wr_sid == '0) || (w.strb != '1);
    assign rd_error = (rd_sid == '0);

    assign req_valid = (state == ISSUE);
    assign bvalid    = (state == B_RESP);
    assign rvalid    = (state == R_RESP);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_accept) begin
                        state <= wr_error ? B_RESP : ISSUE;
                    end else if (rd_accept) begin
                        state <= rd_error ? R_RESP : ISSUE;
                    end
                end
                ISSUE: if (req_ready) state <= BUSY;
                BUSY: if (rsp_done) state <= req.write ? B_RESP : R_RESP;
                B_RESP: if (bready) state <= IDLE;
                R_RESP: if (rready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // response code is settled at acceptance, read data arrives with rsp_done
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            req.write     <= 1'b1;
            req.slave_id  <= wr_sid;
            req.word_addr <= aw.addr[2 +: FRAME_ADDR_W];
            req.wdata     <= w.data;
            b.resp        <= wr_error ? RESP_SLVERR : RESP_OKAY;
        end else if (rd_accept) begin
            req.write     <= 1'b0;
            req.slave_id  <= rd_sid;
            req.word_addr <= ar.addr[2 +: FRAME_ADDR_W];
            req.wdata     <= '0;
            r.data        <= '0;
            r.resp        <= rd_error ? RESP_SLVERR : RESP_OKAY;
        end else if ((state == BUSY) && rsp_done && !req.write) begin
            r.data <= rsp.rdata;
        end
    end

endmodule

//--- logic/bit_shifter.sv
`timescale 1ns/1ps

module bit_shifter #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     load,
    input  payload_t load_value,
    input  logic     shift_en,
    input  logic     serial_in,
    output logic     serial_out,
    output payload_t value
);

    localparam int WIDTH = $bits(payload_t);

    // msb first, new bits enter at the bottom
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            value <= '0;
        end else if (load) begin
            value <= load_value;
        end else if (shift_en) begin
            value <= payload_t'({value[WIDTH-2:0], serial_in});
        end
    end

    // line stays low once a zero-filled word has been shifted out
    assign serial_out = value[WIDTH-1];

endmodule

//--- logic/axil_pkg.sv
package axil_pkg;

    localparam int AXIL_ADDR_W = 16;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_aw_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_ar_t;

    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;
        logic [AXIL_STRB_W-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_t resp;
    } axil_b_t;

    typedef struct packed {
        logic [AXIL_DATA_W-1:0] data;
        axil_resp_t             resp;
    } axil_r_t;

endpackage

//--- logic/serial_bus_pkg.sv
package serial_bus_pkg;

    localparam int DATA_WIDTH   = 32;
    // identities 1..SLAVE_COUNT, 0 means no slave
    localparam int SLAVE_COUNT  = 3;
    localparam int SID_WIDTH    = 2;
    localparam int FRAME_ADDR_W = 12;

    localparam logic [2:0] START_CODE = 3'b111;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // sent on control from the top field down
    typedef struct packed {
        logic [2:0]              start;
        logic [SID_WIDTH-1:0]    slave_id;
        logic                    write;
        logic [FRAME_ADDR_W-1:0] word_addr;
    } ctrl_frame_t;

    localparam int FRAME_BITS = $bits(ctrl_frame_t);

    typedef struct packed {
        logic                    write;
        logic [SID_WIDTH-1:0]    slave_id;
        logic [FRAME_ADDR_W-1:0] word_addr;
        data_t                   wdata;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
    } bus_rsp_t;

endpackage
